// ==== isa_pkg.sv ====
// ##########################################################
// instruction-level encodings shared by dispatch and issue
// the operand word is decoded by the unit that owns the row
// ##########################################################
package isa_pkg;

    localparam int NUM_REGS = 32;

    // unit select, doubles as the status table row index
    typedef enum logic [2:0] {
        FU_ALU  = 3'd0,
        FU_LDST = 3'd1,
        FU_BR   = 3'd2,
        FU_MLS  = 3'd3,
        FU_GEMM = 3'd4
    } fu_sel_e;

    typedef logic [4:0]  regbits_t;
    typedef logic [3:0]  matbits_t;
    typedef logic [31:0] word_t;

    // ALU, load/store and branch operands
    typedef struct packed {
        regbits_t    rs1;
        regbits_t    rs2;
        logic [15:0] imm;
    } scalar_ops_t;

    // matrix operands, rs1 is the scalar address base for loads and stores
    typedef struct packed {
        matbits_t   md;
        matbits_t   ms1;
        matbits_t   ms2;
        matbits_t   ms3;
        regbits_t   rs1;
        logic [4:0] pad;
    } matrix_ops_t;

    // one dispatched operand word, two views
    typedef union packed {
        scalar_ops_t s;
        matrix_ops_t m;
    } operands_u;

endpackage

// ==== datapath_pkg.sv ====
// ##########################################################
// scheduling types for the status tables and issue packet
// tags hold producer unit plus one, zero means operand ready
// ##########################################################
package datapath_pkg;

    import isa_pkg::*;

    localparam int NUM_FU    = 5;
    localparam int NUM_SROWS = 3;
    localparam int NUM_MROWS = 2;
    // first row owned by the matrix table
    localparam int MROW_BASE = 3;
    localparam int AGE_W     = 3;
    localparam int AGE_MAX   = 4;

    typedef logic [2:0] tag_t;

    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    typedef struct packed {
        regbits_t  rd;
        tag_t      t1;
        tag_t      t2;
        tag_t      t3;
        operands_u ops;
    } fust_row_t;

    typedef struct packed {
        logic      valid;
        fu_sel_e   fu;
        regbits_t  rd;
        tag_t      t1;
        tag_t      t2;
        tag_t      t3;
        operands_u ops;
    } dispatch_t;

    typedef struct packed {
        logic              rw_en;
        regbits_t          rw;
        word_t             wdata;
        logic [NUM_FU-1:0] fu_done;
    } wb_t;

    typedef struct packed {
        logic [NUM_FU-1:0] fu_en;
        regbits_t          rd;
        word_t             rdat1;
        word_t             rdat2;
        word_t             imm;
        matbits_t          md;
        matbits_t          ms1;
        matbits_t          ms2;
        matbits_t          ms3;
    } issue_t;

    // drop a tag whose producer signals done this cycle
    function automatic tag_t clear_tag(tag_t t, logic [NUM_FU-1:0] done);
        tag_t r;
        r = t;
        // tags above NUM_FU name no unit and are left alone
        if (t != '0 && int'(t) <= NUM_FU) begin
            if (done[t - 3'd1]) begin
                r = '0;
            end
        end
        return r;
    endfunction

endpackage

// ==== regfile.sv ====
// ##########################################################
// 32 x 32 scalar registers, r0 reads zero
// reads see a write from the same cycle
// ##########################################################
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wen,
    input  regbits_t wsel,
    input  word_t    wdata,
    input  regbits_t rsel1,
    input  regbits_t rsel2,
    output word_t    rdat1,
    output word_t    rdat2
);

    word_t [NUM_REGS-1:0] regs;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    // one read port, shared by both selects
    function automatic word_t read_port(regbits_t sel);
        word_t d;
        if (sel == '0) begin
            d = '0;
        end else if (wen && wsel == sel) begin
            d = wdata;
        end else begin
            d = regs[sel];
        end
        return d;
    endfunction

    always_comb begin
        rdat1 = read_port(rsel1);
        rdat2 = read_port(rsel2);
    end

endmodule

// ==== fust_scalar.sv ====
// ##########################################################
// status rows for ALU, load/store and branch
// t3 is not used by scalar rows and is stored as zero
// ##########################################################
`timescale 1ns/1ps

module fust_scalar
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      en,
    input  fu_sel_e                   row_sel,
    input  fust_row_t                 row_in,
    input  logic [NUM_FU-1:0]         fu_done,
    output fust_row_t [NUM_SROWS-1:0] rows
);

    fust_row_t wr_row;

    always_comb begin
        wr_row    = row_in;
        wr_row.t3 = '0;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            for (int i = 0; i < NUM_SROWS; i++) begin
                // a fresh dispatch wins over a clear to the same row
                if (en && row_sel == fu_sel_e'(i)) begin
                    rows[i] <= wr_row;
                end else begin
                    rows[i].t1 <= clear_tag(rows[i].t1, fu_done);
                    rows[i].t2 <= clear_tag(rows[i].t2, fu_done);
                end
            end
        end
    end

endmodule

// ==== fust_matrix.sv ====
// ##########################################################
// status rows for matrix load/store and GEMM
// row 0 here is unit 3, row 1 is unit 4
// ##########################################################
`timescale 1ns/1ps

module fust_matrix
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      en,
    input  fu_sel_e                   row_sel,
    input  fust_row_t                 row_in,
    input  logic [NUM_FU-1:0]         fu_done,
    output fust_row_t [NUM_MROWS-1:0] rows
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            for (int i = 0; i < NUM_MROWS; i++) begin
                if (en && row_sel == fu_sel_e'(MROW_BASE + i)) begin
                    rows[i] <= row_in;
                end else begin
                    // GEMM can wait on three producers
                    rows[i].t1 <= clear_tag(rows[i].t1, fu_done);
                    rows[i].t2 <= clear_tag(rows[i].t2, fu_done);
                    rows[i].t3 <= clear_tag(rows[i].t3, fu_done);
                end
            end
        end
    end

endmodule

// ==== issue.sv ====
// ##########################################################
// oldest-ready issue, one unit per cycle, no flush, no WAR stall
// on equal age the lower row index issues first
// ##########################################################
`timescale 1ns/1ps

module issue
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic                     CLK,
    input  logic                     nRST,
    input  dispatch_t                disp,
    input  wb_t                      wb,
    input  logic                     freeze,
    output issue_t                   out,
    output logic [NUM_FU-1:0]        busy,
    output fust_state_e [NUM_FU-1:0] fust_state
);

    fust_row_t                 disp_row;
    fust_row_t [NUM_SROWS-1:0] s_rows;
    fust_row_t [NUM_MROWS-1:0] m_rows;
    fust_row_t [NUM_FU-1:0]    rows;
    fust_row_t                 sel_row;
    fust_state_e [NUM_FU-1:0]  state;
    fust_state_e [NUM_FU-1:0]  next_state;
    logic [NUM_FU-1:0][AGE_W-1:0] age;
    logic [AGE_W-1:0]          best_age;
    logic [NUM_FU-1:0]         cand;
    logic [NUM_FU-1:0]         sel_oh;
    logic                      found;
    logic                      sel_valid;
    logic                      s_en;
    logic                      m_en;
    fu_sel_e                   sel_fu;
    regbits_t                  rsel1;
    regbits_t                  rsel2;
    word_t                     rdat1;
    word_t                     rdat2;
    issue_t                    pkt;

    // dispatch goes to whichever table owns the row
    assign disp_row = '{rd: disp.rd, t1: disp.t1, t2: disp.t2, t3: disp.t3, ops: disp.ops};
    assign s_en     = disp.valid && int'(disp.fu) < MROW_BASE;
    assign m_en     = disp.valid && int'(disp.fu) >= MROW_BASE;

    fust_scalar u_fust_scalar (
        .CLK     (CLK),
        .nRST    (nRST),
        .en      (s_en),
        .row_sel (disp.fu),
        .row_in  (disp_row),
        .fu_done (wb.fu_done),
        .rows    (s_rows)
    );

    fust_matrix u_fust_matrix (
        .CLK     (CLK),
        .nRST    (nRST),
        .en      (m_en),
        .row_sel (disp.fu),
        .row_in  (disp_row),
        .fu_done (wb.fu_done),
        .rows    (m_rows)
    );

    regfile u_regfile (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb.rw_en),
        .wsel  (wb.rw),
        .wdata (wb.wdata),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    assign rows = {m_rows, s_rows};

    // a waiting row with no pending tag may issue
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            cand[i] = (state[i] == FUST_WAIT || state[i] == FUST_RDY) &&
                      rows[i].t1 == '0 && rows[i].t2 == '0 && rows[i].t3 == '0;
        end
    end

    always_comb begin : select
        found    = 1'b0;
        sel_fu   = FU_ALU;
        best_age = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (cand[i] && (!found || age[i] > best_age)) begin
                found    = 1'b1;
                sel_fu   = fu_sel_e'(i);
                best_age = age[i];
            end
        end
        sel_valid      = found && !freeze;
        sel_oh         = '0;
        sel_oh[sel_fu] = sel_valid;
    end

    always_comb begin : next_row_state
        next_state = state;
        for (int i = 0; i < NUM_FU; i++) begin
            case (state[i])
                FUST_EMPTY: begin
                    if (disp.valid && disp.fu == fu_sel_e'(i)) begin
                        next_state[i] = FUST_WAIT;
                    end
                end
                FUST_WAIT, FUST_RDY: begin
                    if (sel_oh[i]) begin
                        next_state[i] = FUST_EX;
                    end else if (cand[i]) begin
                        next_state[i] = FUST_RDY;
                    end
                end
                FUST_EX: begin
                    if (wb.fu_done[i]) begin
                        next_state[i] = FUST_EMPTY;
                    end
                end
                default: next_state[i] = FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                state[i] <= FUST_EMPTY;
            end
        end else begin
            state <= next_state;
        end
    end

    // ages move only on dispatch and saturate
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            age <= '0;
        end else if (disp.valid) begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (disp.fu == fu_sel_e'(i)) begin
                    age[i] <= '0;
                end else if (state[i] != FUST_EMPTY && age[i] < AGE_W'(AGE_MAX)) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

    // register reads follow the selected row's operand view
    always_comb begin : decode
        sel_row = rows[sel_fu];
        rsel1   = '0;
        rsel2   = '0;
        if (sel_fu == FU_MLS) begin
            rsel1 = sel_row.ops.m.rs1;
        end else if (sel_fu != FU_GEMM) begin
            rsel1 = sel_row.ops.s.rs1;
            rsel2 = sel_row.ops.s.rs2;
        end
    end

    always_comb begin : packet
        pkt = '0;
        if (sel_valid) begin
            pkt.fu_en = sel_oh;
            pkt.rd    = sel_row.rd;
            case (sel_fu)
                FU_MLS: begin
                    pkt.rdat1 = rdat1;
                    pkt.md    = sel_row.ops.m.md;
                end
                FU_GEMM: begin
                    pkt.md  = sel_row.ops.m.md;
                    pkt.ms1 = sel_row.ops.m.ms1;
                    pkt.ms2 = sel_row.ops.m.ms2;
                    pkt.ms3 = sel_row.ops.m.ms3;
                end
                default: begin
                    pkt.rdat1 = rdat1;
                    pkt.rdat2 = rdat2;
                    pkt.imm   = word_t'(sel_row.ops.s.imm);
                end
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (!freeze) begin
            out <= pkt;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            busy[i] = state[i] != FUST_EMPTY;
        end
    end

    assign fust_state = state;

endmodule

// ==== issue_properties.sv ====
// ##########################################################
// protocol checks bound into every issue instance
// ##########################################################
`timescale 1ns/1ps

module issue_properties
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input logic                     CLK,
    input logic                     nRST,
    input logic                     freeze,
    input issue_t                   out,
    input logic [NUM_FU-1:0]        busy,
    input fust_state_e [NUM_FU-1:0] fust_state
);

    // at most one unit is started per cycle
    a_fu_en_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(out.fu_en))
        else $error("fu_en has more than one bit set");

    a_freeze_hold: assert property (@(posedge CLK) disable iff (!nRST)
        freeze |=> $stable(out))
        else $error("issue packet changed under freeze");

    for (genvar i = 0; i < NUM_FU; i++) begin : g_row
        a_no_skip: assert property (@(posedge CLK) disable iff (!nRST)
            fust_state[i] == FUST_EMPTY |=> fust_state[i] != FUST_EX)
            else $error("row %0d went from empty to execute", i);

        a_busy: assert property (@(posedge CLK) disable iff (!nRST)
            busy[i] == (fust_state[i] != FUST_EMPTY))
            else $error("busy of row %0d disagrees with its state", i);
    end

endmodule

bind issue issue_properties u_issue_properties (.*);

// ==== tb_issue.sv ====
// ##########################################################
// random dispatch, done and writeback against a cycle model
// execute units and dispatch are played by this testbench
// ##########################################################
`timescale 1ns/1ps

module tb_issue
    import isa_pkg::*;
    import datapath_pkg::*;
;

    localparam int NUM_CYCLES = 3000;
    localparam int DRAIN_MAX  = 200;

    logic                     CLK;
    logic                     nRST;
    dispatch_t                disp;
    wb_t                      wb;
    logic                     freeze;
    issue_t                   out;
    logic [NUM_FU-1:0]        busy;
    fust_state_e [NUM_FU-1:0] fust_state;

    // model state and the inputs the DUT samples at the next edge
    fust_state_e m_state [NUM_FU];
    fust_row_t   m_row   [NUM_FU];
    int          m_age   [NUM_FU];
    int          done_cnt[NUM_FU];
    word_t       shadow  [NUM_REGS];
    issue_t      exp_out;
    dispatch_t   cur_disp;
    wb_t         cur_wb;
    logic        cur_freeze;
    logic        draining;
    logic [31:0] seed;
    int          errors;
    int          checks;
    int          waited;

    issue u_issue (
        .CLK        (CLK),
        .nRST       (nRST),
        .disp       (disp),
        .wb         (wb),
        .freeze     (freeze),
        .out        (out),
        .busy       (busy),
        .fust_state (fust_state)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic check(string what, logic [127:0] exp, logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    // register read as the DUT sees it, writes in the same cycle bypass
    function automatic word_t shadow_read(regbits_t r);
        word_t d;
        if (r == '0) begin
            d = '0;
        end else if (cur_wb.rw_en && cur_wb.rw == r) begin
            d = cur_wb.wdata;
        end else begin
            d = shadow[r];
        end
        return d;
    endfunction

    function automatic tag_t drop_done(tag_t t);
        tag_t r;
        r = t;
        if (t != '0 && cur_wb.fu_done[t - 3'd1]) begin
            r = '0;
        end
        return r;
    endfunction

    // one clock edge of the scheduling rules
    task automatic model_step();
        logic [NUM_FU-1:0] cand;
        fust_state_e       ns[NUM_FU];
        issue_t            pkt;
        fust_row_t         r;
        int                sel;
        logic              fnd;
        sel = 0;
        fnd = 1'b0;
        pkt = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            cand[i] = (m_state[i] == FUST_WAIT || m_state[i] == FUST_RDY) &&
                      m_row[i].t1 == '0 && m_row[i].t2 == '0 && m_row[i].t3 == '0;
            if (cand[i] && (!fnd || m_age[i] > m_age[sel])) begin
                fnd = 1'b1;
                sel = i;
            end
        end
        if (fnd && !cur_freeze) begin
            r = m_row[sel];
            pkt.fu_en[sel] = 1'b1;
            pkt.rd         = r.rd;
            if (sel == int'(FU_GEMM)) begin
                pkt.md  = r.ops.m.md;
                pkt.ms1 = r.ops.m.ms1;
                pkt.ms2 = r.ops.m.ms2;
                pkt.ms3 = r.ops.m.ms3;
            end else if (sel == int'(FU_MLS)) begin
                pkt.rdat1 = shadow_read(r.ops.m.rs1);
                pkt.md    = r.ops.m.md;
            end else begin
                pkt.rdat1 = shadow_read(r.ops.s.rs1);
                pkt.rdat2 = shadow_read(r.ops.s.rs2);
                pkt.imm   = {16'h0, r.ops.s.imm};
            end
        end
        if (!cur_freeze) begin
            exp_out = pkt;
        end
        for (int i = 0; i < NUM_FU; i++) begin
            ns[i] = m_state[i];
            case (m_state[i])
                FUST_EMPTY: begin
                    if (cur_disp.valid && int'(cur_disp.fu) == i) begin
                        ns[i] = FUST_WAIT;
                    end
                end
                FUST_EX: begin
                    if (cur_wb.fu_done[i]) begin
                        ns[i] = FUST_EMPTY;
                    end
                end
                default: begin
                    if (fnd && !cur_freeze && sel == i) begin
                        ns[i]       = FUST_EX;
                        done_cnt[i] = next_rand() % 4;
                    end else if (cand[i]) begin
                        ns[i] = FUST_RDY;
                    end
                end
            endcase
            if (cur_disp.valid) begin
                if (int'(cur_disp.fu) == i) begin
                    m_age[i] = 0;
                end else if (m_state[i] != FUST_EMPTY && m_age[i] < AGE_MAX) begin
                    m_age[i]++;
                end
            end
            if (cur_disp.valid && int'(cur_disp.fu) == i) begin
                m_row[i] = '{rd: cur_disp.rd, t1: cur_disp.t1, t2: cur_disp.t2,
                             t3: cur_disp.t3, ops: cur_disp.ops};
            end else begin
                m_row[i].t1 = drop_done(m_row[i].t1);
                m_row[i].t2 = drop_done(m_row[i].t2);
                m_row[i].t3 = drop_done(m_row[i].t3);
            end
        end
        if (cur_wb.rw_en && cur_wb.rw != '0) begin
            shadow[cur_wb.rw] = cur_wb.wdata;
        end
        for (int i = 0; i < NUM_FU; i++) begin
            m_state[i] = ns[i];
        end
    endtask

    // a tag names an occupied unit that is not finishing this cycle
    function automatic tag_t pick_tag(logic [NUM_FU-1:0] done);
        logic [31:0] r;
        int          u;
        r = next_rand();
        u = r % NUM_FU;
        if (r[7] && m_state[u] != FUST_EMPTY && !done[u]) begin
            return tag_t'(u + 1);
        end
        return '0;
    endfunction

    task automatic drive_inputs();
        dispatch_t   d;
        wb_t         w;
        logic [31:0] r;
        int          f;
        w = '0;
        d = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (m_state[i] == FUST_EX) begin
                if (done_cnt[i] == 0) begin
                    w.fu_done[i] = 1'b1;
                end else begin
                    done_cnt[i]--;
                end
            end
        end
        r       = next_rand();
        w.rw_en = r[0];
        w.rw    = r[5:1];
        w.wdata = next_rand();
        r = next_rand();
        f = r % NUM_FU;
        if (!draining && r[8] && m_state[f] == FUST_EMPTY) begin
            d.valid = 1'b1;
            d.fu    = fu_sel_e'(f);
            d.rd    = r[13:9];
            d.ops   = operands_u'(26'(next_rand()));
            d.t1    = pick_tag(w.fu_done);
            d.t2    = pick_tag(w.fu_done);
            // scalar rows have no third source
            if (f >= MROW_BASE) begin
                d.t3 = pick_tag(w.fu_done);
            end
        end
        cur_freeze = (next_rand() % 8) == 0;
        cur_disp   = d;
        cur_wb     = w;
        disp   <= d;
        wb     <= w;
        freeze <= cur_freeze;
    endtask

    task automatic compare_outputs();
        check("out", 128'(exp_out), 128'(out));
        for (int i = 0; i < NUM_FU; i++) begin
            check($sformatf("busy[%0d]", i), 128'(m_state[i] != FUST_EMPTY), 128'(busy[i]));
            check($sformatf("state[%0d]", i), 128'(m_state[i]), 128'(fust_state[i]));
        end
    endtask

    task automatic run_cycle();
        @(posedge CLK);
        model_step();
        drive_inputs();
        @(negedge CLK);
        compare_outputs();
    endtask

    initial begin
        seed       = 32'hdf29;
        errors     = 0;
        checks     = 0;
        draining   = 1'b0;
        nRST       = 1'b0;
        disp       = '0;
        wb         = '0;
        freeze     = 1'b0;
        cur_disp   = '0;
        cur_wb     = '0;
        cur_freeze = 1'b0;
        exp_out    = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            m_state[i]  = FUST_EMPTY;
            m_row[i]    = '0;
            m_age[i]    = 0;
            done_cnt[i] = 0;
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        compare_outputs();
        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle();
        end
        // stop dispatching and let every row finish
        draining = 1'b1;
        waited   = 0;
        while (busy != '0 && waited < DRAIN_MAX) begin
            run_cycle();
            waited++;
        end
        if (busy != '0) begin
            errors++;
            $display("drain timed out, rows still busy after %0d cycles", DRAIN_MAX);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
isa_pkg.sv
datapath_pkg.sv
regfile.sv
fust_scalar.sv
fust_matrix.sv
issue.sv
issue_properties.sv
tb_issue.sv

// ==== Bender.yml ====
package:
  name: issue

sources:
  - isa_pkg.sv
  - datapath_pkg.sv
  - regfile.sv
  - fust_scalar.sv
  - fust_matrix.sv
  - issue.sv
  - target: test
    files:
      - issue_properties.sv
      - tb_issue.sv
